// File: logic/afc_pkg.sv
// shared types and constants for the VCO cap bank frequency calibration
package afc_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int CNT_W     = 14;
    localparam int DIVR_W    = 16;
    localparam int WIN_W     = 7;
    localparam int ACC_W     = DIVR_W + WIN_W;
    localparam int TIMER_W   = 7;
    localparam int FRAC_BITS = 8;

    // starting point of the minimum error search
    localparam logic [CNT_W-1:0] ERR_MAX = {CNT_W{1'b1}};

    // ----------------------------------------------------------------------
    // calibration sequence states
    // ----------------------------------------------------------------------
    typedef enum logic [4:0] {
        st_idle         = 5'd0,
        st_band_init    = 5'd1,
        st_wait_settle  = 5'd2,
        st_cntr_reset   = 5'd3,
        st_cntr_en_pre  = 5'd4,
        st_cntr_en      = 5'd5,
        st_cntr_en_post = 5'd6,
        st_cntr_sync    = 5'd7,
        st_band_update  = 5'd8,
        st_band_set_opt = 5'd9,
        st_wait_final   = 5'd10,
        st_done         = 5'd11
    } afc_state_t;

endpackage

// File: logic/afc_ctrl_sync.sv
// synchronizes the calibration enable and turns its rising edge into a start pulse
`timescale 1ns/1ps

module afc_ctrl_sync (
    input  logic clk_gated,
    input  logic rstn,
    input  logic afc_en,
    output logic afc_start
);

    logic [1:0] en_sync;
    logic       en_sync_d1;
    logic       en_pos;
    logic [1:0] start_dly;

    // two-flop synchronizer, then a registered rising edge detect
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            en_sync    <= 2'b00;
            en_sync_d1 <= 1'b0;
            en_pos     <= 1'b0;
        end else begin
            en_sync    <= {en_sync[0], afc_en};
            en_sync_d1 <= en_sync[1];
            en_pos     <= en_sync[1] & ~en_sync_d1;
        end
    end

    // two more cycles before the run begins
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            start_dly <= 2'b00;
        end else begin
            start_dly <= {start_dly[0], en_pos};
        end
    end

    assign afc_start = start_dly[1];

endmodule

// File: logic/afc_target_calc.sv
// computes the rounded target count divr*(window+1)/256 with a shift-and-add loop
`timescale 1ns/1ps

module afc_target_calc
    import afc_pkg::*;
(
    input  logic              clk_gated,
    input  logic              rstn,
    input  logic              afc_start,
    input  logic [DIVR_W-1:0] divr,
    input  logic [WIN_W-1:0]  rg_afc_cnt_time,
    output logic [CNT_W-1:0]  target
);

    localparam int ITER_W = $clog2(WIN_W + 1);

    logic              busy;
    logic [ITER_W-1:0] iter;
    logic [ACC_W-1:0]  acc;
    logic [ACC_W-1:0]  acc_next;
    logic [ACC_W-1:0]  divr_shift;
    logic [WIN_W:0]    win_len;

    // window length in cycles, one more than the code
    assign win_len = {1'b0, rg_afc_cnt_time} + 1'b1;

    // partial product for the multiplier bit under work
    assign divr_shift = win_len[iter] ? (ACC_W'(divr) << iter) : '0;
    assign acc_next   = acc + divr_shift;

    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            busy   <= 1'b0;
            iter   <= '0;
            acc    <= '0;
            target <= '0;
        end else if (afc_start) begin
            busy <= 1'b1;
            iter <= '0;
            acc  <= '0;
        end else if (busy) begin
            if (iter == ITER_W'(WIN_W)) begin
                // last bit, drop the fraction and round half up
                busy   <= 1'b0;
                target <= acc_next[FRAC_BITS +: CNT_W] + CNT_W'(acc_next[FRAC_BITS-1]);
            end else begin
                iter <= iter + 1'b1;
                acc  <= acc_next;
            end
        end
    end

endmodule

// File: logic/afc_sequencer.sv
// calibration FSM with the shared state timer and the counter control outputs
`timescale 1ns/1ps

module afc_sequencer
    import afc_pkg::*;
#(
    parameter int CAP_BITS = 7
) (
    input  logic                        clk_gated,
    input  logic                        rstn,
    input  logic                        afc_start,
    input  logic [1:0]                  rg_afc_vcostable_time,
    input  logic [WIN_W-1:0]            rg_afc_cnt_time,
    input  logic                        search_last,
    output logic                        run_init,
    output logic                        step,
    output logic [$clog2(CAP_BITS)-1:0] step_idx,
    output logic                        load_opt,
    output logic                        done,
    output logic                        afc_openloop_en,
    output logic                        afc_cntr_rstn,
    output logic                        afc_cntr_en,
    output logic                        afc_cntr_datasyn,
    output logic                        afc_finish
);

    afc_state_t         state;
    afc_state_t         state_nxt;
    logic [TIMER_W-1:0] timer;
    logic [TIMER_W-1:0] settle_m1;
    logic               settle_end;
    logic               cnt_end;

    // settle wait of 2, 4, 8 or 16 cycles
    always_comb begin
        case (rg_afc_vcostable_time)
            2'd0:    settle_m1 = TIMER_W'(1);
            2'd1:    settle_m1 = TIMER_W'(3);
            2'd2:    settle_m1 = TIMER_W'(7);
            default: settle_m1 = TIMER_W'(15);
        endcase
    end

    assign settle_end = (timer == settle_m1);
    assign cnt_end    = (timer == rg_afc_cnt_time);

    // ----------------------------------------------------------------------
    // state machine
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:         if (afc_start) state_nxt = st_band_init;
            st_band_init:    state_nxt = st_wait_settle;
            st_wait_settle:  if (settle_end) state_nxt = st_cntr_reset;
            st_cntr_reset:   state_nxt = st_cntr_en_pre;
            st_cntr_en_pre:  state_nxt = st_cntr_en;
            st_cntr_en:      if (cnt_end) state_nxt = st_cntr_en_post;
            st_cntr_en_post: state_nxt = st_cntr_sync;
            st_cntr_sync:    state_nxt = st_band_update;
            st_band_update:  state_nxt = search_last ? st_band_set_opt : st_band_init;
            st_band_set_opt: state_nxt = st_wait_final;
            st_wait_final:   if (settle_end) state_nxt = st_done;
            st_done:         state_nxt = st_idle;
            default:         state_nxt = st_idle;
        endcase
    end

    // timer restarts whenever the state changes
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            timer <= '0;
        end else if (state_nxt != state) begin
            timer <= '0;
        end else if (state != st_idle) begin
            timer <= timer + 1'b1;
        end
    end

    // measurement number within the run
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            step_idx <= '0;
        end else if (run_init) begin
            step_idx <= '0;
        end else if (step) begin
            step_idx <= step_idx + 1'b1;
        end
    end

    assign run_init = (state == st_idle) && afc_start;
    assign step     = (state == st_band_update);
    assign load_opt = (state == st_band_set_opt);
    assign done     = (state == st_done);

    // ----------------------------------------------------------------------
    // counter control and run flags
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            afc_cntr_rstn    <= 1'b1;
            afc_cntr_en      <= 1'b0;
            afc_cntr_datasyn <= 1'b0;
            afc_openloop_en  <= 1'b0;
            afc_finish       <= 1'b0;
        end else begin
            // one low cycle once the VCO has settled
            afc_cntr_rstn    <= !((state == st_wait_settle) && settle_end);
            afc_cntr_datasyn <= (state == st_cntr_sync);
            afc_openloop_en  <= (state_nxt != st_idle);
            if (state == st_cntr_en_pre) begin
                afc_cntr_en <= 1'b1;
            end else if ((state == st_cntr_en) && cnt_end) begin
                afc_cntr_en <= 1'b0;
            end
            if (run_init) begin
                afc_finish <= 1'b0;
            end else if (done) begin
                afc_finish <= 1'b1;
            end
        end
    end

endmodule

// File: logic/afc_band_search.sv
// binary search over the cap band with tracking of the smallest count error
`timescale 1ns/1ps

module afc_band_search
    import afc_pkg::*;
#(
    parameter int CAP_BITS = 7
) (
    input  logic                        clk_gated,
    input  logic                        rstn,
    input  logic                        run_init,
    input  logic                        step,
    input  logic [$clog2(CAP_BITS)-1:0] step_idx,
    input  logic                        load_opt,
    input  logic                        done,
    input  logic [CNT_W-1:0]            target,
    input  logic [CNT_W-1:0]            a2d_afc_ncntr,
    output logic                        search_last,
    output logic [CAP_BITS-1:0]         afc_vco_capband,
    output logic [CNT_W-1:0]            afc_minerr
);

    localparam int IDX_W = $clog2(CAP_BITS);
    localparam logic [CAP_BITS-1:0] BAND_MID = CAP_BITS'(1) << (CAP_BITS - 1);

    logic [CNT_W:0]      err;
    logic [CNT_W:0]      err_neg;
    logic                err_sign;
    logic [CNT_W-1:0]    err_abs;
    logic [CNT_W-1:0]    err_min;
    logic [CAP_BITS-1:0] band_opt;
    logic [CAP_BITS-1:0] test_mask;
    logic [CAP_BITS-1:0] band_next;

    // ----------------------------------------------------------------------
    // error of the current count
    // ----------------------------------------------------------------------
    assign err      = {1'b0, a2d_afc_ncntr} - {1'b0, target};
    assign err_neg  = -err;
    assign err_sign = err[CNT_W];
    assign err_abs  = err_sign ? err_neg[CNT_W-1:0] : err[CNT_W-1:0];

    assign search_last = (step_idx == IDX_W'(CAP_BITS - 1));

    // bit under test, msb first
    assign test_mask = BAND_MID >> step_idx;

    // count below target means the band is too high, so drop the bit;
    // the next lower bit is tried unless this was the lsb
    assign band_next = (afc_vco_capband & ~(err_sign ? test_mask : '0)) | (test_mask >> 1);

    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            afc_vco_capband <= BAND_MID;
            band_opt        <= BAND_MID;
            err_min         <= ERR_MAX;
        end else if (run_init) begin
            afc_vco_capband <= BAND_MID;
            band_opt        <= BAND_MID;
            err_min         <= ERR_MAX;
        end else if (step) begin
            afc_vco_capband <= band_next;
            // strictly smaller, the earlier band wins a tie
            if (err_abs < err_min) begin
                err_min  <= err_abs;
                band_opt <= afc_vco_capband;
            end
        end else if (load_opt) begin
            afc_vco_capband <= band_opt;
        end
    end

    // result published at the end of the run
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            afc_minerr <= '0;
        end else if (done) begin
            afc_minerr <= err_min;
        end
    end

endmodule

// File: logic/afc_top.sv
// top level of the VCO cap bank automatic frequency calibration
`timescale 1ns/1ps

module afc_top
    import afc_pkg::*;
#(
    parameter int CAP_BITS = 7
) (
    input  logic                clk_gated,
    input  logic                rstn,
    input  logic                afc_en,
    input  logic [DIVR_W-1:0]   divr,
    input  logic [1:0]          rg_afc_vcostable_time,
    input  logic [WIN_W-1:0]    rg_afc_cnt_time,
    input  logic [CNT_W-1:0]    a2d_afc_ncntr,
    output logic                afc_openloop_en,
    output logic [CAP_BITS-1:0] afc_vco_capband,
    output logic                afc_cntr_rstn,
    output logic                afc_cntr_en,
    output logic                afc_cntr_datasyn,
    output logic [CNT_W-1:0]    afc_minerr,
    output logic                afc_finish
);

    localparam int IDX_W = $clog2(CAP_BITS);

    logic             afc_start;
    logic             run_init;
    logic             step;
    logic [IDX_W-1:0] step_idx;
    logic             load_opt;
    logic             done;
    logic             search_last;
    logic [CNT_W-1:0] target;

    afc_ctrl_sync i_ctrl_sync (
        .clk_gated (clk_gated),
        .rstn      (rstn),
        .afc_en    (afc_en),
        .afc_start (afc_start)
    );

    afc_target_calc i_target_calc (
        .clk_gated       (clk_gated),
        .rstn            (rstn),
        .afc_start       (afc_start),
        .divr            (divr),
        .rg_afc_cnt_time (rg_afc_cnt_time),
        .target          (target)
    );

    afc_sequencer #(
        .CAP_BITS (CAP_BITS)
    ) i_sequencer (
        .clk_gated             (clk_gated),
        .rstn                  (rstn),
        .afc_start             (afc_start),
        .rg_afc_vcostable_time (rg_afc_vcostable_time),
        .rg_afc_cnt_time       (rg_afc_cnt_time),
        .search_last           (search_last),
        .run_init              (run_init),
        .step                  (step),
        .step_idx              (step_idx),
        .load_opt              (load_opt),
        .done                  (done),
        .afc_openloop_en       (afc_openloop_en),
        .afc_cntr_rstn         (afc_cntr_rstn),
        .afc_cntr_en           (afc_cntr_en),
        .afc_cntr_datasyn      (afc_cntr_datasyn),
        .afc_finish            (afc_finish)
    );

    afc_band_search #(
        .CAP_BITS (CAP_BITS)
    ) i_band_search (
        .clk_gated       (clk_gated),
        .rstn            (rstn),
        .run_init        (run_init),
        .step            (step),
        .step_idx        (step_idx),
        .load_opt        (load_opt),
        .done            (done),
        .target          (target),
        .a2d_afc_ncntr   (a2d_afc_ncntr),
        .search_last     (search_last),
        .afc_vco_capband (afc_vco_capband),
        .afc_minerr      (afc_minerr)
    );

endmodule

// File: verification/afc_tb_assert.sv
// concurrent checks on the calibration counter control outputs and finish flag
`timescale 1ns/1ps

module afc_tb_assert
    import afc_pkg::*;
(
    input logic       clk_gated,
    input logic       rstn,
    input afc_state_t state,
    input logic       afc_cntr_rstn,
    input logic       afc_cntr_en,
    input logic       afc_cntr_datasyn,
    input logic       afc_finish
);

    // counter never counts while held in reset
    a_en_in_reset: assert property (@(posedge clk_gated) disable iff (!rstn)
        !(afc_cntr_en && !afc_cntr_rstn))
        else $error("afc_cntr_en high while afc_cntr_rstn is low");

    a_rstn_pulse: assert property (@(posedge clk_gated) disable iff (!rstn)
        !afc_cntr_rstn |=> afc_cntr_rstn)
        else $error("afc_cntr_rstn low for more than one cycle");

    a_datasyn_pulse: assert property (@(posedge clk_gated) disable iff (!rstn)
        afc_cntr_datasyn |=> !afc_cntr_datasyn)
        else $error("afc_cntr_datasyn high for more than one cycle");

    // finish only rises on leaving done
    a_finish_rise: assert property (@(posedge clk_gated) disable iff (!rstn)
        $rose(afc_finish) |-> ($past(state) == st_done))
        else $error("afc_finish rose without passing through done");

endmodule

// File: verification/afc_tb.sv
// testbench for the VCO cap bank frequency calibration, with VCO counter model and reference
`timescale 1ns/1ps

module afc_tb
    import afc_pkg::*;
();

    localparam int CAP_BITS = 7;
    localparam int SLOPE    = 16;
    localparam int TIMEOUT  = 4000;
    localparam int N_RUNS   = 6;
    localparam logic [CAP_BITS-1:0] BAND_MID = CAP_BITS'(1 << (CAP_BITS - 1));

    logic                clk_gated = 1'b0;
    logic                rstn;
    logic                afc_en;
    logic [DIVR_W-1:0]   divr;
    logic [1:0]          rg_afc_vcostable_time;
    logic [WIN_W-1:0]    rg_afc_cnt_time;
    logic [CNT_W-1:0]    a2d_afc_ncntr = '0;
    logic                afc_openloop_en;
    logic [CAP_BITS-1:0] afc_vco_capband;
    logic                afc_cntr_rstn;
    logic                afc_cntr_en;
    logic                afc_cntr_datasyn;
    logic [CNT_W-1:0]    afc_minerr;
    logic                afc_finish;

    int                  base = 0;
    int                  errors = 0;
    int                  tests = 0;
    int                  tests_failed = 0;
    int                  seq_count = 0;
    int                  en_len = 0;
    int                  fall_age = 0;
    int                  rst_age = 0;
    logic                fall_armed = 1'b0;
    logic                rst_armed = 1'b0;
    logic                prev_en = 1'b0;
    logic                prev_finish = 1'b0;
    logic                run_started = 1'b0;
    logic                aborted = 1'b0;
    logic [CAP_BITS-1:0] exp_band = '0;
    logic [CNT_W-1:0]    exp_err = '0;

    always #50 clk_gated = ~clk_gated;

    afc_top #(
        .CAP_BITS (CAP_BITS)
    ) i_dut (
        .clk_gated             (clk_gated),
        .rstn                  (rstn),
        .afc_en                (afc_en),
        .divr                  (divr),
        .rg_afc_vcostable_time (rg_afc_vcostable_time),
        .rg_afc_cnt_time       (rg_afc_cnt_time),
        .a2d_afc_ncntr         (a2d_afc_ncntr),
        .afc_openloop_en       (afc_openloop_en),
        .afc_vco_capband       (afc_vco_capband),
        .afc_cntr_rstn         (afc_cntr_rstn),
        .afc_cntr_en           (afc_cntr_en),
        .afc_cntr_datasyn      (afc_cntr_datasyn),
        .afc_minerr            (afc_minerr),
        .afc_finish            (afc_finish)
    );

    bind afc_sequencer afc_tb_assert i_assert (
        .clk_gated        (clk_gated),
        .rstn             (rstn),
        .state            (state),
        .afc_cntr_rstn    (afc_cntr_rstn),
        .afc_cntr_en      (afc_cntr_en),
        .afc_cntr_datasyn (afc_cntr_datasyn),
        .afc_finish       (afc_finish)
    );

    // ------------------------------------------------------------------
    // VCO model and reference
    // ------------------------------------------------------------------
    // count falls linearly with the band, floored at zero
    function automatic int vco_count(input int band);
        int cnt;
        cnt = base - SLOPE * band;
        return (cnt < 0) ? 0 : cnt;
    endfunction

    // counter only follows the VCO while the window is open
    always @(posedge clk_gated) begin
        #1;
        if (!afc_cntr_rstn) begin
            a2d_afc_ncntr <= '0;
        end else if (afc_cntr_en) begin
            a2d_afc_ncntr <= CNT_W'(vco_count(int'(afc_vco_capband)));
        end
    end

    // rounded target, then msb-first search keeping the first smallest error
    function automatic logic [CAP_BITS+CNT_W-1:0] expected_result(input int div_val,
                                                                  input int code);
        int tgt;
        int band;
        int best_band;
        int best_err;
        int diff;
        int mag;
        int mask;
        int i;
        tgt       = (div_val * (code + 1) + 128) / 256;
        band      = 1 << (CAP_BITS - 1);
        best_band = band;
        best_err  = (1 << CNT_W) - 1;
        for (i = 0; i < CAP_BITS; i++) begin
            diff = vco_count(band) - tgt;
            mag  = (diff < 0) ? -diff : diff;
            if (mag < best_err) begin
                best_err  = mag;
                best_band = band;
            end
            mask = 1 << (CAP_BITS - 1 - i);
            if (diff < 0) begin
                band = band & ~mask;
            end
            band = band | (mask >> 1);
        end
        return {best_band[CAP_BITS-1:0], best_err[CNT_W-1:0]};
    endfunction

    task automatic report_mismatch(input string name, input int got, input int exp);
        errors++;
        $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("t=%0t %s", $time, msg);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests, name, errors - err_before);
        end
    endtask

    // ------------------------------------------------------------------
    // comparing process, sampled mid-cycle
    // ------------------------------------------------------------------
    always @(negedge clk_gated) begin
        if (rstn) begin
            if (afc_cntr_en) begin
                en_len++;
            end
            // counter reset pulse leads the window by two cycles
            if (rst_armed) begin
                rst_age++;
            end
            if (!afc_cntr_rstn) begin
                rst_armed = 1'b1;
                rst_age   = 0;
            end
            if (afc_cntr_en && !prev_en) begin
                if (!rst_armed || rst_age != 2) begin
                    report_failure("afc_cntr_en not two cycles after afc_cntr_rstn pulse");
                end
                rst_armed = 1'b0;
            end
            if (afc_cntr_datasyn) begin
                if (!fall_armed || fall_age != 2) begin
                    report_failure("afc_cntr_datasyn not two cycles after afc_cntr_en fell");
                end
                fall_armed = 1'b0;
            end
            if (fall_armed) begin
                fall_age++;
                if (fall_age > 2) begin
                    report_failure("afc_cntr_datasyn missing after afc_cntr_en fell");
                    fall_armed = 1'b0;
                end
            end
            if (prev_en && !afc_cntr_en) begin
                if (en_len != int'(rg_afc_cnt_time) + 1) begin
                    report_mismatch("afc_cntr_en cycles", en_len, int'(rg_afc_cnt_time) + 1);
                end
                seq_count++;
                en_len     = 0;
                fall_armed = 1'b1;
                fall_age   = 1;
            end
            if (afc_openloop_en) begin
                run_started = 1'b1;
            end
            if (afc_openloop_en && afc_finish) begin
                report_failure("afc_finish high while afc_openloop_en is high");
            end
            if (run_started && !afc_openloop_en && !afc_finish) begin
                report_failure("afc_openloop_en and afc_finish both low after a run started");
            end
            // result is final when afc_finish rises
            if (afc_finish && !prev_finish) begin
                if (afc_vco_capband !== exp_band) begin
                    report_mismatch("afc_vco_capband", int'(afc_vco_capband), int'(exp_band));
                end
                if (afc_minerr !== exp_err) begin
                    report_mismatch("afc_minerr", int'(afc_minerr), int'(exp_err));
                end
            end
            prev_en     = afc_cntr_en;
            prev_finish = afc_finish;
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    task automatic wait_openloop(output int edges);
        edges = 0;
        do begin
            @(posedge clk_gated);
            #1;
            edges++;
        end while (!afc_openloop_en && edges < TIMEOUT);
    endtask

    task automatic wait_finish(output int edges);
        edges = 0;
        do begin
            @(posedge clk_gated);
            #1;
            edges++;
        end while (!afc_finish && edges < TIMEOUT);
    endtask

    task automatic run_calibration(input int idx);
        int                        code;
        int                        lim;
        int                        div_val;
        int                        tgt;
        int                        edges;
        int                        err_before;
        int                        i;
        logic                      held_ok;
        logic [CAP_BITS+CNT_W-1:0] expected;
        err_before = errors;
        // keep the target inside the 14-bit count range
        code = int'($urandom % 128);
        lim  = 4194000 / (code + 1);
        if (lim > 65536) begin
            lim = 65536;
        end
        div_val = int'($urandom % lim);
        tgt     = (div_val * (code + 1) + 128) / 256;
        base    = tgt + SLOPE * int'($urandom % 128) + int'($urandom % 16);
        if (base > 16383) begin
            base = 16383;
        end
        expected = expected_result(div_val, code);
        exp_band = expected[CNT_W +: CAP_BITS];
        exp_err  = expected[CNT_W-1:0];

        afc_en                = 1'b0;
        divr                  = div_val[DIVR_W-1:0];
        rg_afc_cnt_time       = code[WIN_W-1:0];
        rg_afc_vcostable_time = 2'(idx % 4);
        repeat (3) @(posedge clk_gated);
        #1;
        seq_count = 0;
        afc_en    = 1'b1;

        wait_openloop(edges);
        if (!afc_openloop_en) begin
            report_failure("timeout waiting for afc_openloop_en after afc_en rose");
            aborted = 1'b1;
        end else begin
            if (edges != 6) begin
                report_mismatch("start latency in cycles", edges, 6);
            end
            if (afc_finish !== 1'b0) begin
                report_mismatch("afc_finish at start", int'(afc_finish), 0);
            end
            wait_finish(edges);
            if (!afc_finish) begin
                report_failure("timeout waiting for afc_finish");
                aborted = 1'b1;
            end else begin
                @(posedge clk_gated);
                #1;
                if (seq_count != CAP_BITS) begin
                    report_mismatch("counter sequences", seq_count, CAP_BITS);
                end
                // afc_en stays high, no second run may follow
                held_ok = 1'b1;
                for (i = 0; i < 40; i++) begin
                    @(posedge clk_gated);
                    #1;
                    if (afc_openloop_en || !afc_finish) begin
                        held_ok = 1'b0;
                    end
                end
                if (!held_ok) begin
                    report_failure("a new run started while afc_en was held high");
                end
            end
        end
        end_test($sformatf("run divr=%0d window=%0d settle=%0d", div_val, code, idx % 4),
                 err_before);
    endtask

    initial begin
        int err_before;
        int i;
        void'($urandom(32'hd6a9));
        rstn                  = 1'b0;
        afc_en                = 1'b0;
        divr                  = '0;
        rg_afc_vcostable_time = '0;
        rg_afc_cnt_time       = '0;
        repeat (3) @(posedge clk_gated);
        #1;
        rstn = 1'b1;

        err_before = errors;
        if (afc_openloop_en !== 1'b0) begin
            report_mismatch("afc_openloop_en", int'(afc_openloop_en), 0);
        end
        if (afc_cntr_en !== 1'b0) begin
            report_mismatch("afc_cntr_en", int'(afc_cntr_en), 0);
        end
        if (afc_cntr_datasyn !== 1'b0) begin
            report_mismatch("afc_cntr_datasyn", int'(afc_cntr_datasyn), 0);
        end
        if (afc_finish !== 1'b0) begin
            report_mismatch("afc_finish", int'(afc_finish), 0);
        end
        if (afc_cntr_rstn !== 1'b1) begin
            report_mismatch("afc_cntr_rstn", int'(afc_cntr_rstn), 1);
        end
        if (afc_vco_capband !== BAND_MID) begin
            report_mismatch("afc_vco_capband", int'(afc_vco_capband), int'(BAND_MID));
        end
        if (afc_minerr !== '0) begin
            report_mismatch("afc_minerr", int'(afc_minerr), 0);
        end
        end_test("reset values", err_before);

        for (i = 1; i <= N_RUNS; i++) begin
            if (!aborted) begin
                run_calibration(i);
            end
        end

        $display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
        if (errors == 0 && !aborted) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
logic/afc_pkg.sv
logic/afc_ctrl_sync.sv
logic/afc_target_calc.sv
logic/afc_sequencer.sv
logic/afc_band_search.sv
logic/afc_top.sv
verification/afc_tb_assert.sv
verification/afc_tb.sv

// File: run.sh
#!/bin/sh
# build the calibration testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module afc_tb -o afc_sim \
    && ./obj_dir/afc_sim > sim.log 2>&1 \
    || echo ">>> FAIL" >> sim.log

cat sim.log

grep -q ">>> FAIL" sim.log && exit 1
exit 0
